//--- include/fe_config.svh
////////////////////////////////////////
// Front-end configuration
// Datapath width, reset PC and predictor options
////////////////////////////////////////

`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

// Data and address width
`define XLEN 32

// First fetch address out of reset
`define PC_INIT 32'h200

// Branch predictor select
// 1 uses the history table, 0 the static backward-taken rule
`define FE_HAS_BPU 1

// History table index width, 64 counters
`define BHT_IDX_BITS 6

`endif

//--- hw/fe_pkg.sv
////////////////////////////////////////
// Front-end types
// Instruction views, exception flags and opcodes
////////////////////////////////////////

`default_nettype none

package fe_pkg;

  ////////////////////////////////////////
  // Constants

  // RV32 major opcodes seen by pre-decode
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // addi x0, x0, 0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

  ////////////////////////////////////////
  // Scalar types

  // Register file address
  typedef logic [4:0] rsd_t;

  // Saturating counter, bit 1 set means taken
  typedef logic [1:0] bp_t;

  ////////////////////////////////////////
  // Instruction formats

  // I-format, imm doubles as CSR address
  typedef struct packed {
    logic [11:0] imm;
    rsd_t        rs1;
    logic [2:0]  funct3;
    rsd_t        rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // SB-format, scattered branch offset
  typedef struct packed {
    logic        imm12;
    logic [5:0]  imm10_5;
    rsd_t        rs2;
    rsd_t        rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm4_1;
    logic        imm11;
    logic [6:0]  opcode;
  } sb_fmt_t;

  // UJ-format, scattered jump offset
  typedef struct packed {
    logic        imm20;
    logic [9:0]  imm10_1;
    logic        imm11;
    logic [7:0]  imm19_12;
    rsd_t        rd;
    logic [6:0]  opcode;
  } uj_fmt_t;

  // One instruction word, several readings
  typedef union packed {
    logic [31:0] raw;
    i_fmt_t      i;
    sb_fmt_t     sb;
    uj_fmt_t     uj;
  } instr_u;

  // Instruction plus pipeline bubble marker
  typedef struct packed {
    logic   bubble;
    instr_u instr;
  } insn_t;

  // Fetch exception flags
  typedef struct packed {
    logic misaligned;
    logic illegal;
    logic any;
  } exc_t;

endpackage

`default_nettype wire

//--- hw/fe_fetch.sv
////////////////////////////////////////
// Instruction fetch
// Program counter, next-PC select and fetch checks
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fe_config.svh"

module fe_fetch
  import fe_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             stall_i,
  input  logic             st_flush_i,
  input  logic             bu_flush_i,
  input  logic             latch_nxt_pc_i,
  input  logic [`XLEN-1:0] st_nxt_pc_i,
  input  logic [`XLEN-1:0] bu_nxt_pc_i,
  input  logic [`XLEN-1:0] pd_nxt_pc_i,
  input  instr_u           imem_rdata_i,
  output logic [`XLEN-1:0] imem_addr_o,
  output logic [`XLEN-1:0] if_pc_o,
  output insn_t            if_insn_o,
  output exc_t             if_exc_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_d;
  logic             bubble_q;
  logic             flush;

  assign flush = st_flush_i | bu_flush_i;

  // Next PC with state flush ahead of branch unit flush
  always_comb begin
    if (st_flush_i) begin
      pc_d = st_nxt_pc_i;
    end else if (bu_flush_i) begin
      pc_d = bu_nxt_pc_i;
    end else if (latch_nxt_pc_i) begin
      pc_d = pd_nxt_pc_i;
    end else if (stall_i) begin
      pc_d = pc_q;
    end else begin
      pc_d = pc_q + `XLEN'd4;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= `PC_INIT;
    end else begin
      pc_q <= pc_d;
    end
  end

  // First word after reset or flush is dropped
  // Held over a stall so it still reaches pre-decode
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bubble_q <= 1'b1;
    end else if (flush) begin
      bubble_q <= 1'b1;
    end else if (!stall_i) begin
      bubble_q <= 1'b0;
    end
  end

  // Memory answers in the same cycle
  assign imem_addr_o = pc_q;
  assign if_pc_o     = pc_q;

  assign if_insn_o.instr  = imem_rdata_i;
  assign if_insn_o.bubble = bubble_q;

  // Fetch checks
  assign if_exc_o.misaligned = |pc_q[1:0];
  assign if_exc_o.illegal    = imem_rdata_i.raw[1:0] != 2'b11;
  assign if_exc_o.any        = if_exc_o.misaligned | if_exc_o.illegal;

  // Under a stall the PC follows one redirect and then holds
  a_pc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i && !flush && $past(stall_i && !flush && latch_nxt_pc_i)
    |=> pc_q == $past(pc_q));

endmodule

`default_nettype wire

//--- hw/fe_bht.sv
////////////////////////////////////////
// Branch history table
// 2-bit saturating counters indexed by PC
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fe_config.svh"

module fe_bht
  import fe_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [`XLEN-1:0] rd_pc_i,
  output bp_t              rd_predict_o,
  input  logic             upd_valid_i,
  input  logic             upd_taken_i,
  input  logic [`XLEN-1:0] upd_pc_i
);

  localparam int unsigned num_entries = 2 ** `BHT_IDX_BITS;

  bp_t                      cnt_q [num_entries];
  logic [`BHT_IDX_BITS-1:0] rd_idx;
  logic [`BHT_IDX_BITS-1:0] upd_idx;

  // Word index, low two PC bits skipped
  assign rd_idx  = rd_pc_i[`BHT_IDX_BITS+1:2];
  assign upd_idx = upd_pc_i[`BHT_IDX_BITS+1:2];

  // Read is combinational, same-cycle update not visible
  assign rd_predict_o = cnt_q[rd_idx];

  ////////////////////////////////////////
  // Training

  // All counters start weakly not taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < num_entries; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (upd_valid_i) begin
      if (upd_taken_i && cnt_q[upd_idx] != 2'b11) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
      end else if (!upd_taken_i && cnt_q[upd_idx] != 2'b00) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
      end
    end
  end

  // Branch unit reports word aligned PCs only
  a_upd_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_valid_i |-> upd_pc_i[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/fe_predecode.sv
////////////////////////////////////////
// Instruction pre-decode
// Register stage, branch prediction, fetch redirect
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fe_config.svh"

module fe_predecode
  import fe_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             id_stall_i,
  input  logic             bu_flush_i,
  input  logic             st_flush_i,
  input  logic             later_exc_i,
  input  logic [`XLEN-1:0] if_pc_i,
  input  insn_t            if_insn_i,
  input  exc_t             if_exc_i,
  input  bp_t              bp_predict_i,
  output logic             pd_stall_o,
  output logic             pd_flush_o,
  output logic             pd_latch_nxt_pc_o,
  output logic [`XLEN-1:0] pd_nxt_pc_o,
  output logic [`XLEN-1:0] pd_pc_o,
  output insn_t            pd_insn_o,
  output exc_t             pd_exc_o,
  output bp_t              pd_bp_predict_o,
  output rsd_t             pd_rs1_o,
  output rsd_t             pd_rs2_o,
  output logic [11:0]      pd_csr_reg_o
);

  logic [6:0]       opcode;
  logic [20:0]      imm_uj;
  logic [12:0]      imm_sb;
  logic [`XLEN-1:0] ext_imm_uj;
  logic [`XLEN-1:0] ext_imm_sb;
  logic             branch_taken;
  bp_t              branch_predicted;
  logic             redirected_q;
  instr_u           instr_q;
  logic             bubble_q;

  assign pd_flush_o = bu_flush_i | st_flush_i;
  assign pd_stall_o = id_stall_i;

  ////////////////////////////////////////
  // Early operand addresses

  // Register file and CSR addresses go ahead unregistered
  assign pd_rs1_o     = if_insn_i.instr.i.rs1;
  assign pd_rs2_o     = if_insn_i.instr.sb.rs2;
  assign pd_csr_reg_o = if_insn_i.instr.i.imm;

  ////////////////////////////////////////
  // Pipeline registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_pc_o <= `PC_INIT;
      instr_q <= INSTR_NOP;
    end else if (!id_stall_i) begin
      pd_pc_o <= if_pc_i;
      instr_q <= if_insn_i.instr;
    end
  end

  // Flush and later-stage faults kill the slot even under stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bubble_q <= 1'b1;
    end else if (pd_flush_o || later_exc_i) begin
      bubble_q <= 1'b1;
    end else if (!id_stall_i) begin
      bubble_q <= if_insn_i.bubble;
    end
  end

  assign pd_insn_o.instr  = instr_q;
  assign pd_insn_o.bubble = bubble_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_exc_o <= '0;
    end else if (pd_flush_o) begin
      pd_exc_o <= '0;
    end else if (!id_stall_i) begin
      pd_exc_o <= if_exc_i;
    end
  end

  ////////////////////////////////////////
  // Branch and jump prediction

  assign opcode = if_insn_i.instr.raw[6:0];

  // Offsets rebuilt from the scattered fields with bit 0 clear
  assign imm_uj = {if_insn_i.instr.uj.imm20, if_insn_i.instr.uj.imm19_12,
                   if_insn_i.instr.uj.imm11, if_insn_i.instr.uj.imm10_1, 1'b0};
  assign imm_sb = {if_insn_i.instr.sb.imm12, if_insn_i.instr.sb.imm11,
                   if_insn_i.instr.sb.imm10_5, if_insn_i.instr.sb.imm4_1, 1'b0};

  assign ext_imm_uj = {{(`XLEN-21){imm_uj[20]}}, imm_uj};
  assign ext_imm_sb = {{(`XLEN-13){imm_sb[12]}}, imm_sb};

  always_comb begin
    branch_taken     = 1'b0;
    branch_predicted = 2'b00;
    pd_nxt_pc_o      = if_pc_i + ext_imm_sb;
    if (!if_insn_i.bubble) begin
      case (opcode)
        // Jumps always taken
        OPC_JAL: begin
          branch_taken     = 1'b1;
          branch_predicted = 2'b10;
          pd_nxt_pc_o      = if_pc_i + ext_imm_uj;
        end
        // Table counter or the static backward-taken rule
        OPC_BRANCH: begin
          branch_taken     = (`FE_HAS_BPU != 0) ? bp_predict_i[1] : ext_imm_sb[`XLEN-1];
          branch_predicted = (`FE_HAS_BPU != 0) ? bp_predict_i
                                                : {ext_imm_sb[`XLEN-1], 1'b0};
        end
        default: branch_taken = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_bp_predict_o <= 2'b00;
    end else if (!id_stall_i) begin
      pd_bp_predict_o <= branch_predicted;
    end
  end

  ////////////////////////////////////////
  // Redirect strobe

  // Remembers a redirect already issued during the current stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      redirected_q <= 1'b0;
    end else if (!id_stall_i || pd_flush_o) begin
      redirected_q <= 1'b0;
    end else if (pd_latch_nxt_pc_o) begin
      redirected_q <= 1'b1;
    end
  end

  assign pd_latch_nxt_pc_o = branch_taken & ~redirected_q;

  // Slot after a flush arrives as a bubble and never steers fetch
  a_no_redirect_on_bubble: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pd_flush_o |=> !pd_latch_nxt_pc_o);

endmodule

`default_nettype wire

//--- hw/fe_top.sv
////////////////////////////////////////
// Front-end top level
// Fetch, history table and pre-decode
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fe_config.svh"

module fe_top
  import fe_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  // Instruction memory
  input  instr_u           imem_rdata_i,
  output logic [`XLEN-1:0] imem_addr_o,
  // Pipeline control
  input  logic             id_stall_i,
  input  logic             bu_flush_i,
  input  logic [`XLEN-1:0] bu_nxt_pc_i,
  input  logic             st_flush_i,
  input  logic [`XLEN-1:0] st_nxt_pc_i,
  input  logic             later_exc_i,
  // Resolved branch training
  input  logic             upd_valid_i,
  input  logic [`XLEN-1:0] upd_pc_i,
  input  logic             upd_taken_i,
  // To decode
  output logic [`XLEN-1:0] pd_pc_o,
  output insn_t            pd_insn_o,
  output exc_t             pd_exc_o,
  output bp_t              pd_bp_predict_o,
  output rsd_t             pd_rs1_o,
  output rsd_t             pd_rs2_o,
  output logic [11:0]      pd_csr_reg_o,
  output logic             pd_flush_o
);

  logic [`XLEN-1:0] if_pc;
  insn_t            if_insn;
  exc_t             if_exc;
  bp_t              if_predict;
  logic             pd_latch_nxt_pc;
  logic [`XLEN-1:0] pd_nxt_pc;
  logic             pd_stall;

  fe_fetch u_fetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .stall_i        (pd_stall),
    .st_flush_i     (st_flush_i),
    .bu_flush_i     (bu_flush_i),
    .latch_nxt_pc_i (pd_latch_nxt_pc),
    .st_nxt_pc_i    (st_nxt_pc_i),
    .bu_nxt_pc_i    (bu_nxt_pc_i),
    .pd_nxt_pc_i    (pd_nxt_pc),
    .imem_rdata_i   (imem_rdata_i),
    .imem_addr_o    (imem_addr_o),
    .if_pc_o        (if_pc),
    .if_insn_o      (if_insn),
    .if_exc_o       (if_exc)
  );

  // Looked up with the fetch PC, result used by pre-decode
  fe_bht u_bht (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_pc_i      (if_pc),
    .rd_predict_o (if_predict),
    .upd_valid_i  (upd_valid_i),
    .upd_taken_i  (upd_taken_i),
    .upd_pc_i     (upd_pc_i)
  );

  fe_predecode u_predecode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_stall_i        (id_stall_i),
    .bu_flush_i        (bu_flush_i),
    .st_flush_i        (st_flush_i),
    .later_exc_i       (later_exc_i),
    .if_pc_i           (if_pc),
    .if_insn_i         (if_insn),
    .if_exc_i          (if_exc),
    .bp_predict_i      (if_predict),
    .pd_stall_o        (pd_stall),
    .pd_flush_o        (pd_flush_o),
    .pd_latch_nxt_pc_o (pd_latch_nxt_pc),
    .pd_nxt_pc_o       (pd_nxt_pc),
    .pd_pc_o           (pd_pc_o),
    .pd_insn_o         (pd_insn_o),
    .pd_exc_o          (pd_exc_o),
    .pd_bp_predict_o   (pd_bp_predict_o),
    .pd_rs1_o          (pd_rs1_o),
    .pd_rs2_o          (pd_rs2_o),
    .pd_csr_reg_o      (pd_csr_reg_o)
  );

endmodule

`default_nettype wire

//--- verif/fe_clk_gen.sv
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fe_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 20 ns period
  localparam int unsigned half_period = 10;
  localparam int unsigned rst_cycles  = 4;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/fe_tb.sv
////////////////////////////////////////
// Front-end testbench
// Memory model, reference PC and table model
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fe_config.svh"

module fe_tb
  import fe_pkg::*;
();

  logic             clk;
  logic             rst_n;
  instr_u           imem_rdata;
  logic [`XLEN-1:0] imem_addr;
  logic             id_stall;
  logic             bu_flush;
  logic             st_flush;
  logic             later_exc;
  logic             upd_valid;
  logic             upd_taken;
  logic [`XLEN-1:0] bu_nxt_pc;
  logic [`XLEN-1:0] st_nxt_pc;
  logic [`XLEN-1:0] upd_pc;
  logic [`XLEN-1:0] pd_pc;
  insn_t            pd_insn;
  exc_t             pd_exc;
  bp_t              pd_bp_predict;
  rsd_t             pd_rs1;
  rsd_t             pd_rs2;
  logic [11:0]      pd_csr;
  logic             pd_flush;

  logic [31:0] mem [64];
  int          seed;
  int          value_errs = 0;
  int          timeouts = 0;

  // Reference fetch and table state
  logic [`XLEN-1:0] ref_pc;
  logic             ref_bubble;
  logic             ref_mark;
  logic [1:0]       ref_cnt [2**`BHT_IDX_BITS];
  // Expected pre-decode registers
  logic [`XLEN-1:0] exp_pd_pc;
  logic [31:0]      exp_word;
  logic             exp_bubble;
  logic [2:0]       exp_exc;
  logic [1:0]       exp_predict;
  // Reference decisions for the current cycle
  logic [31:0]      ref_word;
  logic             is_jal;
  logic             is_branch;
  logic [1:0]       cnt_now;
  logic             ref_redirect;
  logic [`XLEN-1:0] next_pc;
  logic [1:0]       pred_now;
  logic [2:0]       exc_now;
  logic             any_flush;

  fe_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  fe_top u_fe_top (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .imem_rdata_i    (imem_rdata),
    .imem_addr_o     (imem_addr),
    .id_stall_i      (id_stall),
    .bu_flush_i      (bu_flush),
    .bu_nxt_pc_i     (bu_nxt_pc),
    .st_flush_i      (st_flush),
    .st_nxt_pc_i     (st_nxt_pc),
    .later_exc_i     (later_exc),
    .upd_valid_i     (upd_valid),
    .upd_pc_i        (upd_pc),
    .upd_taken_i     (upd_taken),
    .pd_pc_o         (pd_pc),
    .pd_insn_o       (pd_insn),
    .pd_exc_o        (pd_exc),
    .pd_bp_predict_o (pd_bp_predict),
    .pd_rs1_o        (pd_rs1),
    .pd_rs2_o        (pd_rs2),
    .pd_csr_reg_o    (pd_csr),
    .pd_flush_o      (pd_flush)
  );

  // Same-cycle memory with the word index wrapping every 256 bytes
  assign imem_rdata = mem[imem_addr[7:2]];

  ////////////////////////////////////////
  // Encoders and offsets

  // jal x1, off
  function automatic logic [31:0] jal_word(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  // beq x3, x4, off
  function automatic logic [31:0] branch_word(input logic [31:0] off);
    return {off[12], off[10:5], 5'd4, 5'd3, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_offset(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] branch_offset(input logic [31:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    value_errs++;
    $display("error %s: got %h, expected %h", name, got, exp);
  endtask

  ////////////////////////////////////////
  // Reference model

  always_comb begin
    ref_word  = mem[ref_pc[7:2]];
    is_jal    = ref_word[6:0] == 7'b1101111;
    is_branch = ref_word[6:0] == 7'b1100011;
    cnt_now   = ref_cnt[ref_pc[`BHT_IDX_BITS+1:2]];
    any_flush = st_flush | bu_flush;
    // Table counter or the static backward-taken rule
    ref_redirect = !ref_bubble && !ref_mark && (is_jal || (is_branch &&
                   ((`FE_HAS_BPU != 0) ? cnt_now[1] : ref_word[31])));
    if (st_flush) begin
      next_pc = st_nxt_pc;
    end else if (bu_flush) begin
      next_pc = bu_nxt_pc;
    end else if (ref_redirect) begin
      next_pc = ref_pc + (is_jal ? jal_offset(ref_word) : branch_offset(ref_word));
    end else if (id_stall) begin
      next_pc = ref_pc;
    end else begin
      next_pc = ref_pc + 32'd4;
    end
    if (ref_bubble || !(is_jal || is_branch)) begin
      pred_now = 2'b00;
    end else if (is_jal) begin
      pred_now = 2'b10;
    end else begin
      pred_now = (`FE_HAS_BPU != 0) ? cnt_now : {ref_word[31], 1'b0};
    end
    exc_now = {|ref_pc[1:0], ref_word[1:0] != 2'b11,
               (|ref_pc[1:0]) | (ref_word[1:0] != 2'b11)};
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_pc      <= `PC_INIT;
      ref_bubble  <= 1'b1;
      ref_mark    <= 1'b0;
      exp_pd_pc   <= `PC_INIT;
      exp_word    <= 32'h0000_0013;
      exp_bubble  <= 1'b1;
      exp_exc     <= 3'b000;
      exp_predict <= 2'b00;
      for (int i = 0; i < 2**`BHT_IDX_BITS; i++) begin
        ref_cnt[i] <= 2'b01;
      end
    end else begin
      ref_pc <= next_pc;
      if (any_flush) begin
        ref_bubble <= 1'b1;
      end else if (!id_stall) begin
        ref_bubble <= 1'b0;
      end
      // One redirect per stalled instruction
      if (!id_stall || any_flush) begin
        ref_mark <= 1'b0;
      end else if (ref_redirect) begin
        ref_mark <= 1'b1;
      end
      if (!id_stall) begin
        exp_pd_pc   <= ref_pc;
        exp_word    <= ref_word;
        exp_predict <= pred_now;
      end
      if (any_flush || later_exc) begin
        exp_bubble <= 1'b1;
      end else if (!id_stall) begin
        exp_bubble <= ref_bubble;
      end
      if (any_flush) begin
        exp_exc <= 3'b000;
      end else if (!id_stall) begin
        exp_exc <= exc_now;
      end
      // Saturating training
      if (upd_valid && upd_taken && ref_cnt[upd_pc[`BHT_IDX_BITS+1:2]] != 2'b11) begin
        ref_cnt[upd_pc[`BHT_IDX_BITS+1:2]] <= ref_cnt[upd_pc[`BHT_IDX_BITS+1:2]] + 2'b01;
      end else if (upd_valid && !upd_taken && ref_cnt[upd_pc[`BHT_IDX_BITS+1:2]] != 2'b00) begin
        ref_cnt[upd_pc[`BHT_IDX_BITS+1:2]] <= ref_cnt[upd_pc[`BHT_IDX_BITS+1:2]] - 2'b01;
      end
    end
  end

  ////////////////////////////////////////
  // Checks

  a_fetch_addr: assert property (@(posedge clk) disable iff (!rst_n) imem_addr == ref_pc)
    else value_error("imem_addr_o", $sampled(imem_addr), $sampled(ref_pc));
  a_pd_pc: assert property (@(posedge clk) disable iff (!rst_n) pd_pc == exp_pd_pc)
    else value_error("pd_pc_o", $sampled(pd_pc), $sampled(exp_pd_pc));
  a_pd_instr: assert property (@(posedge clk) disable iff (!rst_n)
    pd_insn.instr.raw == exp_word)
    else value_error("pd_insn_o.instr", $sampled(pd_insn.instr.raw), $sampled(exp_word));
  a_pd_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    pd_insn.bubble == exp_bubble)
    else value_error("pd_insn_o.bubble", 32'($sampled(pd_insn.bubble)),
                     32'($sampled(exp_bubble)));
  a_pd_exc: assert property (@(posedge clk) disable iff (!rst_n) pd_exc == exp_exc)
    else value_error("pd_exc_o", 32'($sampled(pd_exc)), 32'($sampled(exp_exc)));
  a_pd_predict: assert property (@(posedge clk) disable iff (!rst_n)
    pd_bp_predict == exp_predict)
    else value_error("pd_bp_predict_o", 32'($sampled(pd_bp_predict)),
                     32'($sampled(exp_predict)));
  // rs1, rs2 and CSR address packed into one value
  a_operands: assert property (@(posedge clk) disable iff (!rst_n)
    {pd_rs1, pd_rs2, pd_csr} == {ref_word[19:15], ref_word[24:20], ref_word[31:20]})
    else value_error("pd_rs1_o/pd_rs2_o/pd_csr_reg_o", 32'($sampled({pd_rs1, pd_rs2, pd_csr})),
                     32'($sampled({ref_word[19:15], ref_word[24:20], ref_word[31:20]})));
  a_pd_flush: assert property (@(posedge clk) disable iff (!rst_n) pd_flush == any_flush)
    else value_error("pd_flush_o", 32'($sampled(pd_flush)), 32'($sampled(any_flush)));
  // Slot killed one cycle after a flush or a later fault
  a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n)
    $past(st_flush || bu_flush) |-> pd_insn.bubble && pd_exc == 3'b000)
    else value_error("pd_insn_o.bubble/pd_exc_o", 32'({$sampled(pd_insn.bubble),
                     $sampled(pd_exc)}), 32'h8);
  a_exc_kills: assert property (@(posedge clk) disable iff (!rst_n)
    $past(later_exc) |-> pd_insn.bubble)
    else value_error("pd_insn_o.bubble", 32'($sampled(pd_insn.bubble)), 32'h1);

  ////////////////////////////////////////
  // Stimulus

  task automatic wait_addr(input logic [31:0] target, input int limit);
    int n;
    n = 0;
    while (imem_addr !== target && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (imem_addr !== target) begin
      timeouts++;
      $display("timeout: fetch address never reached %h", target);
    end
  endtask

  // Random levels with mostly aligned flush targets
  task automatic random_cycle();
    logic [31:0] r;
    r         = $random(seed);
    id_stall  = r[1:0] == 2'b00;
    later_exc = r[5:2] == 4'h0;
    upd_valid = r[7:6] == 2'b00;
    upd_taken = r[8];
    upd_pc    = `PC_INIT + {24'h0, r[14:9], 2'b00};
    bu_flush  = r[18:15] == 4'h0;
    st_flush  = r[22:19] == 4'h0;
    bu_nxt_pc = `PC_INIT + {24'h0, r[28:23], r[29] & r[30], 1'b0};
    st_nxt_pc = `PC_INIT + {24'h0, r[31:26], 2'b00};
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] a;
    int          n;
    seed = 32'h7221c3d3;
    // addi filler with fields taken from the word address
    for (int i = 0; i < 64; i++) begin
      a      = `PC_INIT + 32'(i * 4);
      mem[i] = {a[13:2], a[6:2], 3'b000, a[6:2] ^ 5'h1f, 7'b0010011};
    end
    mem[8]  = jal_word(32'h0000_0010);
    mem[20] = branch_word(32'h0000_000c);
    mem[28] = branch_word(32'h0000_0010);
    // Backward jump onto the branch at 0x270
    mem[40] = jal_word(32'hffff_ffd0);
    mem[44] = branch_word(32'hffff_fff4);
    id_stall  = 1'b0;
    bu_flush  = 1'b0;
    st_flush  = 1'b0;
    later_exc = 1'b0;
    upd_valid = 1'b0;
    upd_taken = 1'b0;
    bu_nxt_pc = '0;
    st_nxt_pc = '0;
    upd_pc    = '0;
    n = 0;
    while (!rst_n && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      timeouts++;
      $display("timeout: reset was never released");
    end
    // Straight run through JAL and untrained branches
    wait_addr(32'h2a0, 80);
    // Two taken updates for the branch at 0x270
    upd_valid = 1'b1;
    upd_taken = 1'b1;
    upd_pc    = 32'h270;
    @(negedge clk);
    @(negedge clk);
    upd_valid = 1'b0;
    // Both flushes at once so the state flush wins
    st_flush  = 1'b1;
    st_nxt_pc = 32'h264;
    bu_flush  = 1'b1;
    bu_nxt_pc = 32'h300;
    @(negedge clk);
    st_flush = 1'b0;
    bu_flush = 1'b0;
    wait_addr(32'h280, 20);
    // Stalled JAL lands on the trained branch that must not redirect again
    bu_flush  = 1'b1;
    bu_nxt_pc = 32'h29c;
    @(negedge clk);
    bu_flush = 1'b0;
    wait_addr(32'h2a0, 10);
    id_stall = 1'b1;
    repeat (3) @(negedge clk);
    id_stall = 1'b0;
    // Misaligned target and then a later-stage fault
    bu_flush  = 1'b1;
    bu_nxt_pc = 32'h242;
    @(negedge clk);
    bu_flush = 1'b0;
    repeat (3) @(negedge clk);
    later_exc = 1'b1;
    @(negedge clk);
    later_exc = 1'b0;
    repeat (500) random_cycle();
    $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeouts);
    if (value_errs == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hw/fe_pkg.sv
hw/fe_fetch.sv
hw/fe_bht.sv
hw/fe_predecode.sv
hw/fe_top.sv
verif/fe_clk_gen.sv
verif/fe_tb.sv

//--- run.sh
#!/bin/sh
# Build the front end with Verilator and run the testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module fe_tb -o fe_tb_sim
out=$(./obj_dir/fe_tb_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'All checks passed'; then
  exit 0
fi
exit 1
